// File: sources.f
+incdir+src
src/conv_pkg.sv
src/reset_seq.sv
src/cbr_datapath.sv
src/cbr_ctrl.sv
src/conv_top.sv
verif/tb_ddr_model.sv
verif/conv_top_assert.sv
verif/tb_conv_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the conv_top testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_conv_top -f sources.f -o sim_tb

# the simulation may stop early on an assertion, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

// File: verif/tb_conv_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_macros.svh"

module tb_conv_top;
  import conv_pkg::*;

  localparam int TIMEOUT = 2000;  // cycles per wait

  logic                   clk_40M;
  logic                   clk_40MHz_locked;
  logic                   start;
  logic                   busy;
  logic                   done;
  logic                   ddr_en;
  logic                   ddr_wr;
  logic [`ADDR_WIDTH-1:0] ddr_addr;
  logic                   ddr_valid;
  cbr_word_u              ddr_wdata;
  cbr_word_u              ddr_rdata;
  integer                 seed;
  int                     done_cnt;
  int                     check_cnt;
  int                     timeout_cnt;

  conv_top uut (
    .clk_40M (clk_40M), .clk_40MHz_locked (clk_40MHz_locked), .start (start),
    .busy (busy), .done (done), .ddr_en (ddr_en), .ddr_wr (ddr_wr),
    .ddr_addr (ddr_addr), .ddr_wdata (ddr_wdata), .ddr_valid (ddr_valid),
    .ddr_rdata (ddr_rdata)
  );

  tb_ddr_model u_mem (
    .clk_40M (clk_40M), .ddr_en (ddr_en), .ddr_wr (ddr_wr), .ddr_addr (ddr_addr),
    .ddr_wdata (ddr_wdata), .ddr_valid (ddr_valid), .ddr_rdata (ddr_rdata)
  );

  bind conv_top conv_top_assert u_assert (
    .clk_40M (clk_40M), .clk_40MHz_locked (clk_40MHz_locked), .rst_n (rst_n),
    .start (start), .busy (busy), .done (done), .ddr_en (ddr_en), .ddr_wr (ddr_wr),
    .ddr_addr (ddr_addr), .ddr_valid (ddr_valid), .dp_valid (dp_valid)
  );

  always #20 clk_40M = ~clk_40M;  // 40 ns period

  always @(posedge clk_40M) begin
    if (done) done_cnt++;
  end

  // advance one cycle to 2 ns past the edge
  task automatic tick();
    @(posedge clk_40M);
    #2;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model of one result word
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [511:0] ref_word(input logic [511:0] src, input int wl,
                                            input int wm, input int wr, input longint b,
                                            input int sh);
    logic [511:0] res;
    longint       acc;
    longint       pl;
    longint       pr;
    res = '0;
    for (int i = 0; i < `LANES; i++) begin
      pl = 0;  // zero padding at the word edges
      pr = 0;
      if (i > 0) pl = longint'($signed(src[8*i-8 +: 8]));
      if (i < `LANES - 1) pr = longint'($signed(src[8*i+8 +: 8]));
      acc = (wl * pl + wm * longint'($signed(src[8*i +: 8])) + wr * pr + b) >>> sh;
      if (acc < 0) acc = 0;
      else if (acc > 127) acc = 127;
      res[8*i +: 8] = acc[7:0];
    end
    return res;
  endfunction

  task automatic wait_reset();
    int t;
    t = 0;
    while (!uut.rst_n && t < TIMEOUT) begin
      tick();
      t++;
    end
    if (!uut.rst_n) begin
      timeout_cnt++;
      $display("timeout: reset never released after clock lock");
    end else if (t < `RST_CNT) begin
      check_cnt++;
      $display("[FAIL] %0t: reset released %0d cycles after lock", $time, t);
    end
  endtask

  // mode selects random (0), large positive (1) or negative (2) pixels
  task automatic run_job(input int n, input int mode, input int src_base, input int dst_base,
                         input bit poke_busy);
    cbr_word_u    cfg_w;
    logic [511:0] src_w;
    int           wl;
    int           wm;
    int           wr;
    int           sh;
    int           t;
    int           wr_before;
    int           rd_before;
    int           done_before;
    longint       b;
    byte          px;
    bit           quiet;
    case (mode)
      0: begin
        wl = $random(seed) % 16;
        wm = $random(seed) % 16;
        wr = $random(seed) % 16;
        b  = $random(seed) % 2048;
        sh = $random(seed) & 7;
      end
      1: begin
        // every lane saturates high
        wl = 1;
        wm = 2;
        wr = 1;
        b  = 5000;
        sh = 1;
      end
      default: begin
        // every lane clamps to zero
        wl = 1;
        wm = 1;
        wr = 1;
        b  = -100;
        sh = 0;
      end
    endcase
    cfg_w = '0;
    cfg_w.cfg.w_left   = 8'(wl);
    cfg_w.cfg.w_mid    = 8'(wm);
    cfg_w.cfg.w_right  = 8'(wr);
    cfg_w.cfg.bias     = 32'(b);
    cfg_w.cfg.shift    = 5'(sh);
    cfg_w.cfg.count    = 16'(n);
    cfg_w.cfg.src_base = 32'(src_base);
    cfg_w.cfg.dst_base = 32'(dst_base);
    u_mem.mem[8'(`CFG_ADDR)] = cfg_w;
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < `LANES; i++) begin
        case (mode)
          0:       px = byte'($random(seed));
          1:       px = byte'(100 + ($random(seed) & 15));
          default: px = byte'(-128 + ($random(seed) & 15));
        endcase
        src_w[8*i +: 8] = px;
      end
      u_mem.mem[8'(src_base + k)]     = src_w;
      u_mem.exp_mem[8'(dst_base + k)] = ref_word(src_w, wl, wm, wr, b, sh);
      u_mem.exp_vld[8'(dst_base + k)] = 1'b1;
    end
    wr_before   = u_mem.write_cnt;
    rd_before   = u_mem.read_cnt;
    done_before = done_cnt;
    start = 1'b1;
    tick();
    start = 1'b0;
    if (poke_busy) begin
      t = 0;
      while (u_mem.write_cnt == wr_before && t < TIMEOUT) begin
        tick();
        t++;
      end
      if (t >= TIMEOUT) begin
        timeout_cnt++;
        $display("timeout: first write of the job never came");
      end
      start = 1'b1;  // lands while busy and must be ignored
      tick();
      start = 1'b0;
    end
    t = 0;
    while (!done && t < TIMEOUT) begin
      tick();
      t++;
    end
    if (!done) begin
      timeout_cnt++;
      $display("timeout: no done within %0d cycles", TIMEOUT);
    end
    quiet = 1'b1;
    for (int q = 0; q < 10; q++) begin
      tick();
      if (busy) quiet = 1'b0;
    end
    if (!quiet) begin
      check_cnt++;
      $display("a start pulse during the job launched another job");
    end
    if (u_mem.write_cnt - wr_before != n) begin
      check_cnt++;
      $display("[FAIL] %0t: job wrote %0d words, expected %0d", $time,
               u_mem.write_cnt - wr_before, n);
    end
    if (u_mem.read_cnt - rd_before != n + 1) begin
      check_cnt++;
      $display("[FAIL] %0t: job read %0d words, expected %0d", $time,
               u_mem.read_cnt - rd_before, n + 1);
    end
    if (done_cnt - done_before != 1) begin
      check_cnt++;
      $display("[FAIL] %0t: done pulsed %0d times, expected 1", $time, done_cnt - done_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed = 76;
    clk_40M = 1'b0;
    clk_40MHz_locked = 1'b0;
    start = 1'b0;
    done_cnt = 0;
    check_cnt = 0;
    timeout_cnt = 0;
    repeat (10) @(posedge clk_40M);
    #2 clk_40MHz_locked = 1'b1;
    wait_reset();
    repeat (3) tick();
    run_job(6, 0, 16, 32, 1'b1);   // random words plus a start pulse while busy
    run_job(6, 1, 48, 64, 1'b0);
    run_job(6, 2, 80, 96, 1'b0);
    run_job(0, 0, 112, 128, 1'b0); // config read only
    $display("errors: %0d mismatches, %0d stray accesses, %0d check failures, %0d timeouts",
             u_mem.mismatch_cnt, u_mem.stray_cnt, check_cnt, timeout_cnt);
    if (u_mem.mismatch_cnt + u_mem.stray_cnt + check_cnt + timeout_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/conv_top_assert.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_macros.svh"

module conv_top_assert (
  input logic                   clk_40M,
  input logic                   clk_40MHz_locked,
  input logic                   rst_n,
  input logic                   start,
  input logic                   busy,
  input logic                   done,
  input logic                   ddr_en,
  input logic                   ddr_wr,
  input logic [`ADDR_WIDTH-1:0] ddr_addr,
  input logic                   ddr_valid,
  input logic                   dp_valid
);

  logic rd_open;  // read strobed and data not back yet

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      rd_open <= 1'b0;
    end else if (ddr_en && !ddr_wr) begin
      rd_open <= 1'b1;
    end else if (ddr_valid) begin
      rd_open <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reset and protocol
  ////////////////////////////////////////////////////////////////////////////

  a_reset_hold: assert property (@(posedge clk_40M)
    $rose(rst_n) |-> $past(clk_40MHz_locked, `RST_CNT))
    else $error("reset released before the hold count after clock lock");
  a_quiet_in_reset: assert property (@(posedge clk_40M) !rst_n |-> !ddr_en && !busy && !done)
    else $error("activity while in reset");
  a_start_reads_cfg: assert property (@(posedge clk_40M) disable iff (!rst_n)
    start && !busy |=> ddr_en && !ddr_wr && ddr_addr == `ADDR_WIDTH'(`CFG_ADDR) && busy)
    else $error("start did not issue the config read");
  a_one_read_open: assert property (@(posedge clk_40M) disable iff (!rst_n) rd_open |-> !ddr_en)
    else $error("request strobed while a read is outstanding");

  // each write lands 2 cycles after its source word
  a_write_after_src: assert property (@(posedge clk_40M) disable iff (!rst_n)
    dp_valid |-> ##2 (ddr_en && ddr_wr))
    else $error("no write 2 cycles after source data");
  a_write_has_src: assert property (@(posedge clk_40M) disable iff (!rst_n)
    ddr_en && ddr_wr |-> $past(dp_valid, 2))
    else $error("write without source data 2 cycles before");

  a_done_pulse: assert property (@(posedge clk_40M) disable iff (!rst_n) done |=> !done)
    else $error("done longer than one cycle");
  a_done_follows: assert property (@(posedge clk_40M) disable iff (!rst_n)
    done |-> $fell(busy) && ($past(ddr_en && ddr_wr) || $past(ddr_valid)))
    else $error("done not 1 cycle after last write or config read");
  a_busy_falls_with_done: assert property (@(posedge clk_40M) disable iff (!rst_n)
    $fell(busy) |-> done)
    else $error("busy fell without done");

endmodule

`default_nettype wire

// File: verif/tb_ddr_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_model (
  input  logic         clk_40M,
  input  logic         ddr_en,
  input  logic         ddr_wr,
  input  logic [31:0]  ddr_addr,
  input  logic [511:0] ddr_wdata,
  output logic         ddr_valid,
  output logic [511:0] ddr_rdata
);

  localparam int DEPTH = 256;  // words, index is 8 bits

  logic [511:0] mem     [0:DEPTH-1];
  logic [511:0] exp_mem [0:DEPTH-1];  // filled by the testbench
  logic         exp_vld [0:DEPTH-1];  // cleared once written
  int           write_cnt;
  int           read_cnt;
  int           mismatch_cnt;
  int           stray_cnt;
  integer       seed;
  logic         rd_pend;
  int           rd_wait;
  logic [7:0]   rd_idx;
  logic [7:0]   wr_idx;
  logic         valid_nx;

  initial begin
    seed = 76;
    ddr_valid = 1'b0;
    ddr_rdata = '0;
    rd_pend = 1'b0;
    rd_wait = 0;
    write_cnt = 0;
    read_cnt = 0;
    mismatch_cnt = 0;
    stray_cnt = 0;
    for (int a = 0; a < DEPTH; a++) begin
      mem[8'(a)]     = {16{32'(a) ^ 32'hA5C3_0000}};  // address tagged fill
      exp_mem[8'(a)] = '0;
      exp_vld[8'(a)] = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // strobes sampled on the edge, responses driven 2 ns later
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_40M) begin
    valid_nx = 1'b0;
    if (ddr_en && !ddr_wr) begin
      read_cnt++;
      if (ddr_addr >= DEPTH) begin
        stray_cnt++;
        $display("read outside the model range, address %0d at %0t", ddr_addr, $time);
      end
      rd_idx  = ddr_addr[7:0];
      rd_pend = 1'b1;
      rd_wait = $random(seed) & 7;  // 1 to 8 cycles
    end
    if (ddr_en && ddr_wr) begin
      write_cnt++;
      wr_idx = ddr_addr[7:0];
      if (ddr_addr >= DEPTH || !exp_vld[wr_idx]) begin
        stray_cnt++;
        $display("unexpected write to address %0d at %0t", ddr_addr, $time);
      end else if (ddr_wdata !== exp_mem[wr_idx]) begin
        mismatch_cnt++;
        $display("[FAIL] %0t: write data mismatch at address %0d", $time, ddr_addr);
      end
      if (ddr_addr < DEPTH) begin
        mem[wr_idx]     = ddr_wdata;
        exp_vld[wr_idx] = 1'b0;  // a second write here is stray
      end
    end
    if (rd_pend) begin
      if (rd_wait == 0) begin
        valid_nx = 1'b1;
        rd_pend  = 1'b0;
      end else begin
        rd_wait--;
      end
    end
    #2;
    ddr_valid = valid_nx;
    if (valid_nx) ddr_rdata = mem[rd_idx];
  end

endmodule

`default_nettype wire

// File: src/conv_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_macros.svh"

module conv_top (
  input  logic                   clk_40M,
  input  logic                   clk_40MHz_locked,
  input  logic                   start,
  output logic                   busy,
  output logic                   done,
  output logic                   ddr_en,
  output logic                   ddr_wr,
  output logic [`ADDR_WIDTH-1:0] ddr_addr,
  output conv_pkg::cbr_word_u    ddr_wdata,
  input  logic                   ddr_valid,
  input  conv_pkg::cbr_word_u    ddr_rdata
);
  import conv_pkg::*;

  logic               rst_n;      // released after lock + hold
  logic               dp_valid;   // source word into datapath
  pixel_t             w_left;
  pixel_t             w_mid;
  pixel_t             w_right;
  logic signed [31:0] bias;
  logic [4:0]         shift;
  logic               res_valid;  // result word back to ctrl
  cbr_word_u          res_word;

  ////////////////////////////////////////////////////////////////////////////
  // reset, control, datapath
  ////////////////////////////////////////////////////////////////////////////

  reset_seq u_reset_seq (
    .clk_40M          (clk_40M),
    .clk_40MHz_locked (clk_40MHz_locked),
    .rst_n            (rst_n)
  );

  cbr_ctrl u_cbr_ctrl (
    .clk_40M   (clk_40M),
    .rst_n     (rst_n),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .ddr_en    (ddr_en),
    .ddr_wr    (ddr_wr),
    .ddr_addr  (ddr_addr),
    .ddr_wdata (ddr_wdata),
    .ddr_valid (ddr_valid),
    .ddr_rdata (ddr_rdata),   // cfg view
    .dp_valid  (dp_valid),
    .w_left    (w_left),
    .w_mid     (w_mid),
    .w_right   (w_right),
    .bias      (bias),
    .shift     (shift),
    .res_valid (res_valid),
    .res_word  (res_word)
  );

  cbr_datapath u_cbr_datapath (
    .clk_40M   (clk_40M),
    .rst_n     (rst_n),
    .in_valid  (dp_valid),
    .in_word   (ddr_rdata),   // pixel view, same bus
    .w_left    (w_left),
    .w_mid     (w_mid),
    .w_right   (w_right),
    .bias      (bias),
    .shift     (shift),
    .out_valid (res_valid),
    .out_word  (res_word)
  );

endmodule

`default_nettype wire

// File: src/cbr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_macros.svh"

module cbr_ctrl (
  input  logic                   clk_40M,
  input  logic                   rst_n,
  input  logic                   start,
  output logic                   busy,
  output logic                   done,
  output logic                   ddr_en,
  output logic                   ddr_wr,
  output logic [`ADDR_WIDTH-1:0] ddr_addr,
  output conv_pkg::cbr_word_u    ddr_wdata,
  input  logic                   ddr_valid,
  input  conv_pkg::cbr_word_u    ddr_rdata,
  output logic                   dp_valid,
  output conv_pkg::pixel_t       w_left,
  output conv_pkg::pixel_t       w_mid,
  output conv_pkg::pixel_t       w_right,
  output logic signed [31:0]     bias,
  output logic [4:0]             shift,
  input  logic                   res_valid,
  input  conv_pkg::cbr_word_u    res_word
);
  import conv_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // state encoding
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_CFG_RD   = 3'd1;  // strobe config read
  localparam logic [2:0] S_CFG_WAIT = 3'd2;
  localparam logic [2:0] S_SRC_RD   = 3'd3;  // strobe source read
  localparam logic [2:0] S_SRC_WAIT = 3'd4;
  localparam logic [2:0] S_COMPUTE  = 3'd5;  // datapath register stage
  localparam logic [2:0] S_WRITE    = 3'd6;  // strobe result write
  localparam logic [2:0] S_DONE     = 3'd7;

  logic [2:0]             state;
  logic [2:0]             state_nx;
  cbr_cfg_t               cfg_q;      // latched job setup
  logic [15:0]            word_idx;   // current source word
  logic                   last_word;
  logic [`ADDR_WIDTH-1:0] src_addr;
  logic [`ADDR_WIDTH-1:0] dst_addr;

  assign last_word = (word_idx + 16'd1 == cfg_q.count);
  assign src_addr  = cfg_q.src_base + `ADDR_WIDTH'(word_idx);
  assign dst_addr  = cfg_q.dst_base + `ADDR_WIDTH'(word_idx);

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nx = state;
    case (state)
      S_IDLE: begin
        if (start) state_nx = S_CFG_RD;
      end
      S_CFG_RD: state_nx = S_CFG_WAIT;
      S_CFG_WAIT: begin
        if (ddr_valid) begin
          // count comes straight off the bus, cfg_q loads on this edge
          state_nx = (ddr_rdata.cfg.count == 16'd0) ? S_DONE : S_SRC_RD;
        end
      end
      S_SRC_RD: state_nx = S_SRC_WAIT;
      S_SRC_WAIT: begin
        if (ddr_valid) state_nx = S_COMPUTE;
      end
      S_COMPUTE: begin
        if (res_valid) state_nx = S_WRITE;
      end
      S_WRITE: state_nx = last_word ? S_DONE : S_SRC_RD;
      S_DONE: state_nx = start ? S_CFG_RD : S_IDLE;  // busy already low here
      default: state_nx = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // word counter, cleared while the config read is pending
  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      word_idx <= '0;
    end else if (state == S_CFG_WAIT) begin
      word_idx <= '0;
    end else if (state == S_WRITE) begin
      word_idx <= word_idx + 16'd1;  // next word after each write
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // payload registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M) begin
    if (state == S_CFG_WAIT && ddr_valid) begin
      cfg_q <= ddr_rdata.cfg;  // cfg view of the word
    end
  end

  always_ff @(posedge clk_40M) begin
    if (state == S_COMPUTE && res_valid) begin
      ddr_wdata <= res_word;  // lines up with the write strobe
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory port and status, decoded from state
  ////////////////////////////////////////////////////////////////////////////

  assign ddr_en = (state == S_CFG_RD) || (state == S_SRC_RD) || (state == S_WRITE);
  assign ddr_wr = (state == S_WRITE);

  always_comb begin
    case (state)
      S_CFG_RD: ddr_addr = `ADDR_WIDTH'(`CFG_ADDR);
      S_SRC_RD: ddr_addr = src_addr;
      S_WRITE:  ddr_addr = dst_addr;
      default:  ddr_addr = '0;
    endcase
  end

  assign dp_valid = ddr_valid && (state == S_SRC_WAIT);  // source words only
  assign busy     = (state != S_IDLE) && (state != S_DONE);
  assign done     = (state == S_DONE);

  // datapath coefficients
  assign w_left  = cfg_q.w_left;
  assign w_mid   = cfg_q.w_mid;
  assign w_right = cfg_q.w_right;
  assign bias    = cfg_q.bias;
  assign shift   = cfg_q.shift;

endmodule

`default_nettype wire

// File: src/cbr_datapath.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_macros.svh"

module cbr_datapath (
  input  logic                clk_40M,
  input  logic                rst_n,
  input  logic                in_valid,
  input  conv_pkg::cbr_word_u in_word,
  input  conv_pkg::pixel_t    w_left,
  input  conv_pkg::pixel_t    w_mid,
  input  conv_pkg::pixel_t    w_right,
  input  logic signed [31:0]  bias,
  input  logic [4:0]          shift,
  output logic                out_valid,
  output conv_pkg::cbr_word_u out_word
);
  import conv_pkg::*;

  // 3 products of 16 bits plus a 32-bit bias, two bits of headroom
  localparam int ACC_W = 34;

  ////////////////////////////////////////////////////////////////////////////
  // one lane: conv, bias, shift, relu, saturate
  ////////////////////////////////////////////////////////////////////////////

  function automatic pixel_t cbr_lane(
    input pixel_t             pl,   // left neighbour
    input pixel_t             pm,   // centre
    input pixel_t             pr,   // right neighbour
    input pixel_t             wl,
    input pixel_t             wm,
    input pixel_t             wr,
    input logic signed [31:0] b,
    input logic [4:0]         sh
  );
    logic signed [15:0]      prod_l;
    logic signed [15:0]      prod_m;
    logic signed [15:0]      prod_r;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] shd;
    pixel_t                  res;
    prod_l = pl * wl;  // 8x8 signed fits in 16
    prod_m = pm * wm;
    prod_r = pr * wr;
    acc    = prod_l + prod_m + prod_r + b;  // all signed, sign extended
    shd    = acc >>> sh;
    if (shd[ACC_W-1]) begin
      res = '0;  // relu
    end else if (shd > ACC_W'(127)) begin
      res = 8'sd127;  // clip top
    end else begin
      res = pixel_t'(shd[7:0]);
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // lane array
  ////////////////////////////////////////////////////////////////////////////

  // word with a zero pixel on each side, so edge lanes need no special case
  pixel_t [`LANES+1:0] ext_pix;
  cbr_word_u           res_c;

  assign ext_pix = {pixel_t'(0), in_word.pix, pixel_t'(0)};

  always_comb begin : lane_calc
    for (int i = 0; i < `LANES; i++) begin
      // ext_pix[i+1] is lane i of the input word
      res_c.pix[i] = cbr_lane(ext_pix[i], ext_pix[i+1], ext_pix[i+2],
                              w_left, w_mid, w_right, bias, shift);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register, one cycle latency
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_40M) begin
    if (in_valid) begin
      out_word <= res_c;  // held until next source word
    end
  end

endmodule

`default_nettype wire

// File: src/reset_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "conv_macros.svh"

module reset_seq (
  input  logic clk_40M,
  input  logic clk_40MHz_locked,
  output logic rst_n
);

  localparam int CNT_W = $clog2(`RST_CNT + 1);  // must hold RST_CNT itself

  logic [CNT_W-1:0] hold_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // hold counter, restarts whenever lock drops
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      hold_cnt <= '0;
    end else if (hold_cnt != CNT_W'(`RST_CNT)) begin
      hold_cnt <= hold_cnt + 1'b1;  // saturates at RST_CNT
    end
  end

  // registered release, so rst_n rises on a clock edge
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_n <= 1'b0;
    end else begin
      rst_n <= (hold_cnt == CNT_W'(`RST_CNT));  // stays high once reached
    end
  end

endmodule

`default_nettype wire

// File: src/conv_pkg.sv
`default_nettype none
`include "conv_macros.svh"

package conv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // pixel and word types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic signed [7:0] pixel_t;  // one lane

  // configuration word layout, first field sits at the msb end
  typedef struct packed {
    pixel_t                   w_left;    // tap on lane i-1
    pixel_t                   w_mid;     // tap on lane i
    pixel_t                   w_right;   // tap on lane i+1
    logic signed [31:0]       bias;
    logic [4:0]               shift;     // arithmetic right shift
    logic [15:0]              count;     // source words in the job
    logic [`ADDR_WIDTH-1:0]   src_base;
    logic [`ADDR_WIDTH-1:0]   dst_base;
    // unused remainder of the word
    logic [`DDR_WIDTH-(3*8+32+5+16+2*`ADDR_WIDTH)-1:0] pad;
  } cbr_cfg_t;

  // same 512 bits, seen as pixels or as job setup
  typedef union packed {
    pixel_t [`LANES-1:0] pix;  // lane 0 in the low byte
    cbr_cfg_t            cfg;
  } cbr_word_u;

endpackage

`default_nettype wire

// File: src/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// memory word geometry
////////////////////////////////////////////////////////////////////////////

// one ddr word per access
`define DDR_WIDTH 512
// 8-bit pixels per word
`define LANES 64
// word address, not byte address
`define ADDR_WIDTH 32

////////////////////////////////////////////////////////////////////////////
// job setup and reset
////////////////////////////////////////////////////////////////////////////

// config word lives here
`define CFG_ADDR 0
// cycles held in reset after lock
`define RST_CNT 64

`endif
